// ==== common/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define CACHE_SETS 128           // direct mapped, one block per set
`define CACHE_WORDS_PER_BLOCK 8  // 16-byte blocks

// main memory
`define MEM_WORDS 32768          // full 16-bit byte address space
`define MEM_LATENCY 4            // cycles from read request to rvalid

`endif

// ==== common/cache_pkg.sv ====
package cache_pkg;

	// 16-bit byte address, split as tttt tsss ssss bbbb
	typedef logic [15:0] addr_t;

	// one data word, same width as the processor datapath
	typedef logic [15:0] word_t;

	// address fields
	typedef logic [4:0] tag_t;      // addr[15:11]
	typedef logic [6:0] set_idx_t;  // addr[10:4], one of 128 sets
	typedef logic [2:0] word_idx_t; // addr[3:1], word within the block

	// miss handling states
	typedef enum logic [1:0] {
		FILL_IDLE, // waiting for a miss
		FILL_REQ,  // issuing the block reads, one per cycle
		FILL_WAIT, // all reads issued, draining the returns
		FILL_TAG   // block complete, tag and valid written
	} fill_state_t;

endpackage

// ==== cache/meta_data_array.sv ====
`timescale 1ns/1ps

module meta_data_array (
	input  logic                clk,
	input  logic                rst_n,
	input  cache_pkg::set_idx_t set_idx,
	input  cache_pkg::tag_t     tag_in,
	input  logic                write,     // fill complete, mark set valid
	output cache_pkg::tag_t     tag_out,
	output logic                valid_out
);

	`include "cache_defs.svh"

	import cache_pkg::*;

	logic [`CACHE_SETS-1:0] set_sel;       // one-hot set enable
	logic [`CACHE_SETS-1:0] valid;
	tag_t                   tags [`CACHE_SETS];

	assign set_sel = `CACHE_SETS'(1) << set_idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;                    // cache starts empty
		end else begin
			for (int i = 0; i < `CACHE_SETS; i++) begin
				if (write && set_sel[i])
					valid[i] <= 1'b1;
			end
		end
	end

	// one tag per set, written together with its valid bit
	always_ff @(posedge clk) begin
		for (int i = 0; i < `CACHE_SETS; i++) begin
			if (write && set_sel[i])
				tags[i] <= tag_in;
		end
	end

	assign tag_out   = tags[set_idx];       // async read
	assign valid_out = valid[set_idx];

endmodule

// ==== cache/data_array.sv ====
`timescale 1ns/1ps

module data_array (
	input  logic                 clk,
	input  cache_pkg::set_idx_t  set_idx,
	input  cache_pkg::word_idx_t word_idx,
	input  cache_pkg::word_t     data_in,
	input  logic                 write,     // fill word or store hit
	output cache_pkg::word_t     data_out
);

	`include "cache_defs.svh"

	import cache_pkg::*;

	logic [`CACHE_SETS-1:0]            set_sel;   // one-hot set enable
	logic [`CACHE_WORDS_PER_BLOCK-1:0] word_sel;  // one-hot word enable
	word_t                             mem [`CACHE_SETS][`CACHE_WORDS_PER_BLOCK];

	assign set_sel  = `CACHE_SETS'(1) << set_idx;
	assign word_sel = `CACHE_WORDS_PER_BLOCK'(1) << word_idx;

	// single word written per cycle, where set and word enables meet
	always_ff @(posedge clk) begin
		for (int i = 0; i < `CACHE_SETS; i++) begin
			for (int j = 0; j < `CACHE_WORDS_PER_BLOCK; j++) begin
				if (write && set_sel[i] && word_sel[j])
					mem[i][j] <= data_in;
			end
		end
	end

	assign data_out = mem[set_idx][word_idx]; // async read, hit logic qualifies it

endmodule

// ==== cache/cache_fill_fsm.sv ====
`timescale 1ns/1ps

module cache_fill_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 miss,        // request without a hit
	input  cache_pkg::addr_t     miss_addr,   // address of the missing request
	input  logic                 mem_rvalid,  // one returned word
	output logic                 busy,
	output logic                 mem_rd,      // read request to memory
	output cache_pkg::addr_t     mem_rd_addr,
	output logic                 fill_write,  // write returned word into data array
	output cache_pkg::word_idx_t fill_word,   // which word of the block
	output cache_pkg::addr_t     fill_addr,   // block base, steers set and tag
	output logic                 tag_write    // tag and valid, doubles as fill_done
);

	`include "cache_defs.svh"

	import cache_pkg::*;

	localparam word_idx_t LAST_WORD = word_idx_t'(`CACHE_WORDS_PER_BLOCK - 1);

	fill_state_t state;
	fill_state_t state_nxt;
	addr_t       blk_base;   // latched on the miss
	word_idx_t   issue_cnt;  // next word to request
	word_idx_t   ret_cnt;    // next word to come back
	logic        filling;    // returns are accepted

	assign filling = (state == FILL_REQ) | (state == FILL_WAIT);

	always_comb begin
		state_nxt = state;
		case (state)
			FILL_IDLE: if (miss) state_nxt = FILL_REQ;
			FILL_REQ: if (issue_cnt == LAST_WORD) state_nxt = FILL_WAIT; // last read out
			FILL_WAIT: if (mem_rvalid && ret_cnt == LAST_WORD) state_nxt = FILL_TAG;
			FILL_TAG: state_nxt = FILL_IDLE;   // request hits next cycle
			default: state_nxt = FILL_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= FILL_IDLE;
			issue_cnt <= '0;
			ret_cnt   <= '0;
		end else begin
			state <= state_nxt;
			if (state == FILL_IDLE) begin
				issue_cnt <= '0;
				ret_cnt   <= '0;
			end else begin
				if (state == FILL_REQ)
					issue_cnt <= issue_cnt + 1'b1; // one read per cycle
				if (filling && mem_rvalid)
					ret_cnt <= ret_cnt + 1'b1;     // reads return in order
			end
		end
	end

	// block base only, offset bits cleared
	always_ff @(posedge clk) begin
		if (state == FILL_IDLE && miss)
			blk_base <= {miss_addr[15:4], 4'b0000};
	end

	assign busy        = (state != FILL_IDLE);
	assign mem_rd      = (state == FILL_REQ);
	assign mem_rd_addr = {blk_base[15:4], issue_cnt, 1'b0}; // base + 2*issue_cnt
	assign fill_write  = filling & mem_rvalid;
	assign fill_word   = ret_cnt;
	assign fill_addr   = blk_base;
	assign tag_write   = (state == FILL_TAG);

endmodule

// ==== cache/cache.sv ====
`timescale 1ns/1ps

module cache (
	input  logic            clk,
	input  logic            rst_n,

	// pipeline side
	input  logic            mem_read,   // load request, held while stall
	input  cache_pkg::addr_t read_addr,
	input  logic            mem_write,  // store request, held while stall
	input  cache_pkg::addr_t write_addr,
	input  cache_pkg::word_t write_data,
	output cache_pkg::word_t data_out,  // load data, valid when stall is low
	output logic            stall,      // pipeline must hold its request
	output logic            fill_done,  // one cycle pulse at end of a fill

	// memory side
	input  logic            mem_rvalid, // read return strobe
	input  cache_pkg::word_t mem_rdata,
	output logic            mem_rd,
	output logic            mem_wr,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata
);

	import cache_pkg::*;

	logic      busy;         // fill in progress
	logic      req;          // any pipeline request
	logic      hit;
	logic      miss;
	logic      wr_hit;       // store that completes this cycle
	logic      fill_write;   // fsm writes a returned word
	logic      tag_write;    // fsm writes tag and valid
	logic      valid_out;
	logic      arr_write;
	addr_t     act_addr;     // address presented to both arrays
	addr_t     fill_addr;    // block base of the fill
	addr_t     fill_rd_addr; // address of the current fill read
	tag_t      act_tag;
	tag_t      tag_out;
	set_idx_t  act_set;
	word_idx_t act_word;
	word_idx_t fill_word;
	word_idx_t arr_word;
	word_t     arr_wdata;

	cache_fill_fsm u_fill_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.miss       (miss),
		.miss_addr  (act_addr),
		.mem_rvalid (mem_rvalid),
		.busy       (busy),
		.mem_rd     (mem_rd),
		.mem_rd_addr(fill_rd_addr),
		.fill_write (fill_write),
		.fill_word  (fill_word),
		.fill_addr  (fill_addr),
		.tag_write  (tag_write)
	);

	// fill owns the arrays, otherwise stores take priority over loads
	assign act_addr = busy ? fill_addr :
			mem_write ? write_addr : read_addr;

	assign act_tag  = act_addr[15:11];
	assign act_set  = act_addr[10:4];
	assign act_word = act_addr[3:1];   // byte bit 0 ignored

	assign req  = mem_read | mem_write;
	assign hit  = valid_out & (tag_out == act_tag);
	assign miss = req & ~hit;          // fsm only reacts to this when idle

	assign stall = busy | miss;        // hits never stall

	meta_data_array u_meta (
		.clk      (clk),
		.rst_n    (rst_n),
		.set_idx  (act_set),
		.tag_in   (act_tag),         // fill base tag while tag_write
		.write    (tag_write),
		.tag_out  (tag_out),
		.valid_out(valid_out)
	);

	// the fill tag is not stored until FILL_TAG ends, so a fill never hits
	assign wr_hit    = mem_write & hit;
	assign arr_write = fill_write | wr_hit; // no write on a miss
	assign arr_word  = fill_write ? fill_word : act_word;
	assign arr_wdata = fill_write ? mem_rdata : write_data;

	data_array u_data (
		.clk     (clk),
		.set_idx (act_set),
		.word_idx(arr_word),
		.data_in (arr_wdata),
		.write   (arr_write),
		.data_out(data_out)       // async read of the requested word
	);

	// stores go through to memory once they hit
	assign mem_wr    = wr_hit;
	assign mem_wdata = write_data;
	assign mem_addr  = busy ? fill_rd_addr : write_addr;

	assign fill_done = tag_write;

endmodule

// ==== verilog/memory_model.sv ====
`timescale 1ns/1ps

module memory_model (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             rd,      // accepted every cycle it is high
	input  logic             wr,      // applied at this edge
	input  cache_pkg::addr_t addr,    // byte address
	input  cache_pkg::word_t wdata,
	output logic             rvalid,  // MEM_LATENCY cycles after rd
	output cache_pkg::word_t rdata
);

	`include "cache_defs.svh"

	import cache_pkg::*;

	localparam int IDX_W = $clog2(`MEM_WORDS);

	logic [IDX_W-1:0]        mem_idx;   // word address
	word_t                   mem [`MEM_WORDS];
	logic [`MEM_LATENCY-1:0] vld_pipe;  // bit 0 is the newest request
	word_t                   data_pipe [`MEM_LATENCY];

	assign mem_idx = addr[IDX_W:1];

	// word i holds i ^ a5a5, testbench shadow uses the same rule
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++)
			mem[i] = word_t'(i) ^ 16'hA5A5;
	end

	always_ff @(posedge clk) begin
		if (wr)
			mem[mem_idx] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[`MEM_LATENCY-2:0], rd};
	end

	// data sampled at issue, then shifted along with its valid bit
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[mem_idx];
		for (int s = 1; s < `MEM_LATENCY; s++)
			data_pipe[s] <= data_pipe[s-1];
	end

	assign rvalid = vld_pipe[`MEM_LATENCY-1];
	assign rdata  = data_pipe[`MEM_LATENCY-1];

endmodule

// ==== verilog/cache_mem_top.sv ====
`timescale 1ns/1ps

module cache_mem_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mem_read,
	input  cache_pkg::addr_t read_addr,
	input  logic             mem_write,
	input  cache_pkg::addr_t write_addr,
	input  cache_pkg::word_t write_data,
	output cache_pkg::word_t data_out,
	output logic             stall,
	output logic             fill_done
);

	import cache_pkg::*;

	logic  mem_rd;     // fill reads
	logic  mem_wr;     // write-through stores
	addr_t mem_addr;
	word_t mem_wdata;
	logic  mem_rvalid;
	word_t mem_rdata;

	cache u_cache (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_read  (mem_read),
		.read_addr (read_addr),
		.mem_write (mem_write),
		.write_addr(write_addr),
		.write_data(write_data),
		.mem_rvalid(mem_rvalid),
		.mem_rdata (mem_rdata),
		.data_out  (data_out),
		.stall     (stall),
		.fill_done (fill_done),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	memory_model u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.rd    (mem_rd),
		.wr    (mem_wr),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rvalid(mem_rvalid),
		.rdata (mem_rdata)
	);

endmodule

// ==== tests/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic busy,
	input logic stall,
	input logic fill_done,
	input logic mem_rd,
	input logic mem_wr
);

	logic [3:0] rd_run;   // consecutive cycles with mem_rd so far
	logic       seen_req; // any request since reset

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_run   <= '0;
			seen_req <= 1'b0;
		end else begin
			if (!mem_rd)
				rd_run <= '0;
			else if (rd_run != 4'hf)
				rd_run <= rd_run + 4'd1; // saturates
			if (mem_read || mem_write)
				seen_req <= 1'b1;
		end
	end

	// write-through only on a hit, never inside a fill
	no_wr_in_fill: assert property (@(posedge clk) disable iff (!rst_n) !(mem_wr && busy))
		else $error("memory write issued while a fill is in progress");

	fill_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) fill_done |=> !fill_done)
		else $error("fill_done held for more than one cycle");

	// ninth back-to-back read would be past the block
	rd_burst_len: assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && rd_run == 4'd8))
		else $error("mem_rd high for more than eight consecutive cycles");

	idle_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(!seen_req && !mem_read && !mem_write) |-> !stall)
		else $error("stall raised before any request arrived");

endmodule

bind cache cache_checker u_checker (
	.clk      (clk),
	.rst_n    (rst_n),
	.mem_read (mem_read),
	.mem_write(mem_write),
	.busy     (busy),
	.stall    (stall),
	.fill_done(fill_done),
	.mem_rd   (mem_rd),
	.mem_wr   (mem_wr)
);

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

	`include "cache_defs.svh"

	import cache_pkg::*;

	localparam int NUM_REQ = 425; // directed requests plus 400 random
	localparam int TIMEOUT_CYCLES = NUM_REQ * (10 + `MEM_LATENCY) + 100;

	logic  clk;
	logic  rst_n;
	logic  mem_read;
	addr_t read_addr;
	logic  mem_write;
	addr_t write_addr;
	word_t write_data;
	word_t data_out;
	logic  stall;
	logic  fill_done;

	word_t       shadow [`MEM_WORDS];   // reference copy of main memory
	word_t       exp_word;
	int          fill_cnt = 0;          // fill_done pulses seen
	int          reads_checked = 0;
	int          err_cnt = 0;
	string       test_name = "reset";
	logic [31:0] lcg_state = 32'd44;
	tag_t        conflict_tags [4] = '{5'd3, 5'd9, 5'd17, 5'd30};

	cache_mem_top UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_read  (mem_read),
		.read_addr (read_addr),
		.mem_write (mem_write),
		.write_addr(write_addr),
		.write_data(write_data),
		.data_out  (data_out),
		.stall     (stall),
		.fill_done (fill_done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;             // 100 ns period
	end

	// memory starts as word index xor a5a5
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++)
			shadow[i] = word_t'(i) ^ 16'hA5A5;
	end

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];            // upper bits, better period
	endfunction

	function automatic word_t exp_read(input addr_t a);
		return shadow[a[15:1]];             // byte bit 0 ignored
	endfunction

	task automatic stop_on_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic check_count(input string what, input int expv, input int actv);
		assert (actv == expv) else begin
			err_cnt++;
			$display("ERROR %s: %s expected %0d actual %0d", test_name, what, expv, actv);
			stop_on_failure();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			err_cnt++;
			$display("%s: %s", test_name, what);
			stop_on_failure();
		end
	endtask

	// returns once the request is accepted, i.e. stall low at a falling edge
	task automatic wait_complete(output int stalls);
		stalls = 0;
		@(negedge clk);
		while (stall) begin
			stalls++;
			@(negedge clk);
		end
	endtask

	task automatic issue_read(input addr_t a, output int stalls);
		@(posedge clk);
		mem_write <= 1'b0;
		mem_read  <= 1'b1;
		read_addr <= a;
		wait_complete(stalls);
	endtask

	task automatic issue_write(input addr_t a, input word_t d, output int stalls);
		@(posedge clk);
		mem_read   <= 1'b0;
		mem_write  <= 1'b1;
		write_addr <= a;
		write_data <= d;
		wait_complete(stalls);
	endtask

	// compares completed reads and tracks completed writes, mid-cycle
	always @(negedge clk) begin
		if (rst_n && fill_done)
			fill_cnt++;
		if (rst_n && !stall) begin
			if (mem_read) begin
				exp_word = exp_read(read_addr);
				assert (data_out === exp_word) else begin
					err_cnt++;
					$display("ERROR %s: read %h expected %h actual %h",
						test_name, read_addr, exp_word, data_out);
					stop_on_failure();
				end
				reads_checked++;
			end
			if (mem_write)
				shadow[write_addr[15:1]] = write_data; // lands at the next edge
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("simulation timed out in %s, the cache never released stall", test_name);
		stop_on_failure();
	end

	initial begin
		int    stalls;
		int    fills;
		addr_t a;
		logic [15:0] r;
		mem_read   <= 1'b0;
		read_addr  <= '0;
		mem_write  <= 1'b0;
		write_addr <= '0;
		write_data <= '0;
		rst_n      <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "read_miss_then_hit";
		fills = fill_cnt;
		issue_read(16'h1230, stalls);
		check_true(stalls > 0, "read of an unseen block did not stall");
		check_count("fill_done pulses", fills + 1, fill_cnt);
		issue_read(16'h1234, stalls);       // same block
		check_count("stall cycles", 0, stalls);

		test_name = "whole_block_fill";
		fills = fill_cnt;
		for (int k = 0; k < `CACHE_WORDS_PER_BLOCK; k++) begin
			issue_read({12'h123, 3'(k), 1'b0}, stalls);
			check_count("stall cycles", 0, stalls);
		end
		check_count("fill_done pulses", fills, fill_cnt);

		test_name = "write_hit";
		issue_write(16'h1236, 16'hBEEF, stalls);
		check_count("stall cycles", 0, stalls);
		issue_read(16'h1236, stalls);
		check_count("stall cycles", 0, stalls);
		fills = fill_cnt;
		issue_read(16'h1A36, stalls);       // same set, other tag, evicts
		issue_read(16'h1236, stalls);       // refill must see the store
		check_count("fill_done pulses", fills + 2, fill_cnt);

		test_name = "write_miss";
		fills = fill_cnt;
		issue_write(16'h4560, 16'h1357, stalls);
		check_true(stalls > 0, "write to an uncached block did not stall");
		check_count("fill_done pulses", fills + 1, fill_cnt);
		issue_read(16'h4562, stalls);       // neighbour, memory value
		check_count("stall cycles", 0, stalls);
		issue_read(16'h4560, stalls);
		check_count("stall cycles", 0, stalls);

		test_name = "conflict_eviction";
		for (int round = 0; round < 2; round++) begin
			for (int i = 0; i < 4; i++) begin
				fills = fill_cnt;
				issue_read({conflict_tags[i], 7'h55, 4'h6}, stalls);
				check_count("fill_done pulses", fills + 1, fill_cnt);
			end
		end

		test_name = "random_traffic";
		for (int n = 0; n < 400; n++) begin
			r = lcg_next();
			a = {3'b000, r[1:0], 5'b00000, r[3:2], r[6:4], 1'b0}; // 4 tags x 4 sets
			if (r[8])
				issue_write(a, lcg_next(), stalls);
			else
				issue_read(a, stalls);
		end

		@(posedge clk);
		mem_read  <= 1'b0;
		mem_write <= 1'b0;
		repeat (4) @(posedge clk);
		check_true(reads_checked > 0, "no read was ever compared");
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_on_failure();
		end
	end

endmodule

// ==== filelist.f ====
+incdir+common
common/cache_pkg.sv
cache/meta_data_array.sv
cache/data_array.sv
cache/cache_fill_fsm.sv
cache/cache.sv
verilog/memory_model.sv
verilog/cache_mem_top.sv
tests/cache_checker.sv
tests/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cache_tb -f filelist.f -o sim_cache

# the simulator exits non-zero on a failure, the log decides
./obj_dir/sim_cache > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
